//--- hw/stepper_pkg.sv
`default_nettype none

package stepper_pkg;

  // Datapath widths
  localparam int unsigned addr_w  = 5;
  localparam int unsigned phase_w = 8;
  localparam int unsigned off_w   = 10;
  localparam int unsigned blank_w = 8;

  // Register map, byte offsets
  localparam logic [addr_w-1:0] reg_ctrl      = 5'h00;
  localparam logic [addr_w-1:0] reg_fastdecay = 5'h04;
  localparam logic [addr_w-1:0] reg_blank     = 5'h08;
  localparam logic [addr_w-1:0] reg_off       = 5'h0c;
  localparam logic [addr_w-1:0] reg_min_on    = 5'h10;
  // Read only, faultn in bit 0 and phase count in bits 15:8
  localparam logic [addr_w-1:0] reg_status    = 5'h14;

  // Values loaded at reset
  localparam logic [off_w-1:0]   default_fastdecay = 10'd706;
  localparam logic [blank_w-1:0] default_blank     = 8'd20;
  localparam logic [off_w-1:0]   default_off       = 10'd800;
  localparam logic [blank_w-1:0] default_min_on    = 8'd10;

  // AXI write channel states
  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_t;

endpackage

`default_nettype wire

//--- hw/stepper_regs.sv
`default_nettype none

module stepper_regs (
  input  wire                               clk,
  input  wire                               resetn,
  input  wire  [stepper_pkg::addr_w-1:0]    awaddr,
  input  wire                               awvalid,
  input  wire  [31:0]                       wdata,
  input  wire  [3:0]                        wstrb,
  input  wire                               wvalid,
  input  wire                               bready,
  input  wire  [stepper_pkg::addr_w-1:0]    araddr,
  input  wire                               arvalid,
  input  wire                               rready,
  input  wire                               faultn,
  input  wire  [stepper_pkg::phase_w-1:0]   phase_ct,
  output logic                              awready,
  output logic                              wready,
  output logic                              bvalid,
  output logic [1:0]                        bresp,
  output logic                              arready,
  output logic                              rvalid,
  output logic [31:0]                       rdata,
  output logic [1:0]                        rresp,
  output logic                              config_enable,
  output logic                              config_invert_highside,
  output logic                              config_invert_lowside,
  output logic [stepper_pkg::off_w-1:0]     config_fastdecay_threshold,
  output logic [stepper_pkg::blank_w-1:0]   blank_time,
  output logic [stepper_pkg::off_w-1:0]     off_time,
  output logic [stepper_pkg::blank_w-1:0]   min_on_time
);

  stepper_pkg::wr_state_t wr_state;
  logic                   wr_fire;
  logic                   rd_fire;
  logic [31:0]            rd_mux;

  // Address and data are taken together, never while a response is pending
  assign wr_fire = (wr_state != stepper_pkg::wr_resp) && awvalid && wvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign bvalid  = (wr_state == stepper_pkg::wr_resp);
  assign bresp   = 2'b00;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_state <= stepper_pkg::wr_idle;
    end else begin
      case (wr_state)
        stepper_pkg::wr_idle: begin
          if (wr_fire) begin
            wr_state <= stepper_pkg::wr_resp;
          end else if (awvalid || wvalid) begin
            // One channel arrived early, wait for its partner
            wr_state <= stepper_pkg::wr_data;
          end
        end
        stepper_pkg::wr_data: begin
          if (wr_fire) begin
            wr_state <= stepper_pkg::wr_resp;
          end
        end
        stepper_pkg::wr_resp: begin
          if (bready) begin
            wr_state <= stepper_pkg::wr_idle;
          end
        end
        default: wr_state <= stepper_pkg::wr_idle;
      endcase
    end
  end

  // Configuration registers with per byte strobes
  always_ff @(posedge clk) begin
    if (!resetn) begin
      config_enable              <= 1'b0;
      config_invert_highside     <= 1'b0;
      config_invert_lowside      <= 1'b0;
      config_fastdecay_threshold <= stepper_pkg::default_fastdecay;
      blank_time                 <= stepper_pkg::default_blank;
      off_time                   <= stepper_pkg::default_off;
      min_on_time                <= stepper_pkg::default_min_on;
    end else if (wr_fire) begin
      case (awaddr)
        stepper_pkg::reg_ctrl: begin
          if (wstrb[0]) begin
            config_enable          <= wdata[0];
            config_invert_highside <= wdata[1];
            config_invert_lowside  <= wdata[2];
          end
        end
        stepper_pkg::reg_fastdecay: begin
          if (wstrb[0]) begin
            config_fastdecay_threshold[7:0] <= wdata[7:0];
          end
          if (wstrb[1]) begin
            config_fastdecay_threshold[stepper_pkg::off_w-1:8] <= wdata[stepper_pkg::off_w-1:8];
          end
        end
        stepper_pkg::reg_blank: begin
          if (wstrb[0]) begin
            blank_time <= wdata[stepper_pkg::blank_w-1:0];
          end
        end
        stepper_pkg::reg_off: begin
          if (wstrb[0]) begin
            off_time[7:0] <= wdata[7:0];
          end
          if (wstrb[1]) begin
            off_time[stepper_pkg::off_w-1:8] <= wdata[stepper_pkg::off_w-1:8];
          end
        end
        stepper_pkg::reg_min_on: begin
          if (wstrb[0]) begin
            min_on_time <= wdata[stepper_pkg::blank_w-1:0];
          end
        end
        // Status and unmapped offsets drop the write
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_mux = '0;
    case (araddr)
      stepper_pkg::reg_ctrl: begin
        rd_mux[2:0] = {config_invert_lowside, config_invert_highside, config_enable};
      end
      stepper_pkg::reg_fastdecay: rd_mux[stepper_pkg::off_w-1:0] = config_fastdecay_threshold;
      stepper_pkg::reg_blank:     rd_mux[stepper_pkg::blank_w-1:0] = blank_time;
      stepper_pkg::reg_off:       rd_mux[stepper_pkg::off_w-1:0] = off_time;
      stepper_pkg::reg_min_on:    rd_mux[stepper_pkg::blank_w-1:0] = min_on_time;
      stepper_pkg::reg_status: begin
        rd_mux[0]    = faultn;
        rd_mux[15:8] = phase_ct;
      end
      default: rd_mux = '0;
    endcase
  end

  // Single entry read response
  assign arready = !rvalid;
  assign rd_fire = arvalid && arready;
  assign rresp   = 2'b00;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

//--- hw/commutation_decoder.sv
`default_nettype none

module commutation_decoder (
  input  wire [stepper_pkg::phase_w-1:0] phase_ct,
  output logic                           s1,
  output logic                           s2,
  output logic                           s3,
  output logic                           s4
);

  logic [1:0] quadrant;

  // Full step position is the top two bits of the count
  assign quadrant = phase_ct[stepper_pkg::phase_w-1 -: 2];

  always_comb begin
    case (quadrant)
      2'd0: begin
        {s1, s2, s3, s4} = 4'b1010;
      end
      2'd1: begin
        {s1, s2, s3, s4} = 4'b0110;
      end
      2'd2: begin
        {s1, s2, s3, s4} = 4'b0101;
      end
      default: begin
        // Winding A back to positive, B stays negative
        {s1, s2, s3, s4} = 4'b1001;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/chopper_timers.sv
`default_nettype none

module chopper_timers (
  input  wire                               clk,
  input  wire                               resetn,
  input  wire                               offtimer_en,
  input  wire  [stepper_pkg::off_w-1:0]     off_time,
  input  wire  [stepper_pkg::blank_w-1:0]   blank_time,
  input  wire  [stepper_pkg::blank_w-1:0]   min_on_time,
  output logic [stepper_pkg::off_w-1:0]     off_timer,
  output logic [stepper_pkg::blank_w-1:0]   blank_timer,
  output logic [stepper_pkg::blank_w-1:0]   minimum_on_timer
);

  logic off_ending;

  // Last cycle of the off period
  assign off_ending = (off_timer == stepper_pkg::off_w'(1));

  // Off period counter
  always_ff @(posedge clk) begin
    if (!resetn) begin
      off_timer <= '0;
    end else if (offtimer_en) begin
      off_timer <= off_time;
    end else if (off_timer != '0) begin
      off_timer <= off_timer - 1'b1;
    end
  end

  // Blanking hides the switching spike after drive resumes
  always_ff @(posedge clk) begin
    if (!resetn) begin
      blank_timer <= '0;
    end else if (off_ending) begin
      blank_timer <= blank_time;
    end else if (blank_timer != '0) begin
      blank_timer <= blank_timer - 1'b1;
    end
  end

  // A new off period inside this window is treated as a fault
  always_ff @(posedge clk) begin
    if (!resetn) begin
      minimum_on_timer <= '0;
    end else if (off_ending) begin
      minimum_on_timer <= min_on_time;
    end else if (minimum_on_timer != '0) begin
      minimum_on_timer <= minimum_on_timer - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/microstepper_control.sv
`default_nettype none

module microstepper_control (
  input  wire                               clk,
  input  wire                               resetn,
  input  wire                               step,
  input  wire                               dir,
  input  wire                               enable_in,
  input  wire  [stepper_pkg::off_w-1:0]     config_fastdecay_threshold,
  input  wire                               config_invert_highside,
  input  wire                               config_invert_lowside,
  input  wire                               analog_cmp1,
  input  wire                               analog_cmp2,
  input  wire                               s1,
  input  wire                               s2,
  input  wire                               s3,
  input  wire                               s4,
  input  wire  [stepper_pkg::blank_w-1:0]   blank_timer0,
  input  wire  [stepper_pkg::blank_w-1:0]   blank_timer1,
  input  wire  [stepper_pkg::off_w-1:0]     off_timer0,
  input  wire  [stepper_pkg::off_w-1:0]     off_timer1,
  input  wire  [stepper_pkg::blank_w-1:0]   minimum_on_timer0,
  input  wire  [stepper_pkg::blank_w-1:0]   minimum_on_timer1,
  output logic                              phase_a1_l_out,
  output logic                              phase_a2_l_out,
  output logic                              phase_b1_l_out,
  output logic                              phase_b2_l_out,
  output logic                              phase_a1_h_out,
  output logic                              phase_a2_h_out,
  output logic                              phase_b1_h_out,
  output logic                              phase_b2_h_out,
  output logic                              faultn,
  output logic                              offtimer_en0,
  output logic                              offtimer_en1,
  output logic [stepper_pkg::phase_w-1:0]   phase_ct
);

  logic [2:0] step_r;
  logic [1:0] dir_r;
  logic       step_pulse;
  logic       enable;
  logic       fast0, fast1;
  logic       slow0, slow1;
  logic       fault_now;
  logic       a1_h, a2_h, b1_h, b2_h;
  logic       a1_l, a2_l, b1_l, b2_l;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      enable     <= 1'b0;
      step_pulse <= 1'b0;
    end else begin
      enable     <= enable_in;
      step_pulse <= (step_r == 3'b001);
    end
    step_r <= {step_r[1:0], step};
    dir_r  <= {dir_r[0], dir};
  end

  // Count one position per detected step edge, wrapping
  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase_ct <= '0;
    end else if (step_pulse) begin
      phase_ct <= dir_r[1] ? phase_ct + 1'b1 : phase_ct - 1'b1;
    end
  end

  // Off timer restarted before the minimum on time ran out
  assign fault_now = ((off_timer0 != '0) && (minimum_on_timer0 != '0)) ||
                     ((off_timer1 != '0) && (minimum_on_timer1 != '0));

  always_ff @(posedge clk) begin
    if (!resetn) begin
      faultn <= 1'b1;
    end else if (enable && fault_now) begin
      faultn <= 1'b0;
    end
  end

  // Off period starts with fast decay, then finishes in slow decay
  assign fast0 = off_timer0 >= config_fastdecay_threshold;
  assign fast1 = off_timer1 >= config_fastdecay_threshold;
  assign slow0 = (off_timer0 != '0) && !fast0;
  assign slow1 = (off_timer1 != '0) && !fast1;

  // Fast decay reverses the bridge, slow decay shorts through the low sides
  assign a1_h = !slow0 && (s1 ^ fast0);
  assign a2_h = !slow0 && (s2 ^ fast0);
  assign b1_h = !slow1 && (s3 ^ fast1);
  assign b2_h = !slow1 && (s4 ^ fast1);
  assign a1_l = slow0 || !(s1 ^ fast0);
  assign a2_l = slow0 || !(s2 ^ fast0);
  assign b1_l = slow1 || !(s3 ^ fast1);
  assign b2_l = slow1 || !(s4 ^ fast1);

  // Disabled windings are braked with all low sides on
  assign phase_a1_l_out = config_invert_lowside ^ (a1_l || !enable);
  assign phase_a2_l_out = config_invert_lowside ^ (a2_l || !enable);
  assign phase_b1_l_out = config_invert_lowside ^ (b1_l || !enable);
  assign phase_b2_l_out = config_invert_lowside ^ (b2_l || !enable);

  assign phase_a1_h_out = config_invert_highside ^ (a1_h && faultn && enable);
  assign phase_a2_h_out = config_invert_highside ^ (a2_h && faultn && enable);
  assign phase_b1_h_out = config_invert_highside ^ (b1_h && faultn && enable);
  assign phase_b2_h_out = config_invert_highside ^ (b2_h && faultn && enable);

  // Peak current reached outside blanking starts a fixed off time
  assign offtimer_en0 = analog_cmp1 && (blank_timer0 == '0) && (off_timer0 == '0);
  assign offtimer_en1 = analog_cmp2 && (blank_timer1 == '0) && (off_timer1 == '0);

endmodule

`default_nettype wire

//--- hw/stepper_top.sv
`default_nettype none

module stepper_top (
  input  wire                               clk,
  input  wire                               resetn,
  input  wire  [stepper_pkg::addr_w-1:0]    awaddr,
  input  wire                               awvalid,
  output logic                              awready,
  input  wire  [31:0]                       wdata,
  input  wire  [3:0]                        wstrb,
  input  wire                               wvalid,
  output logic                              wready,
  output logic                              bvalid,
  input  wire                               bready,
  output logic [1:0]                        bresp,
  input  wire  [stepper_pkg::addr_w-1:0]    araddr,
  input  wire                               arvalid,
  output logic                              arready,
  output logic                              rvalid,
  input  wire                               rready,
  output logic [31:0]                       rdata,
  output logic [1:0]                        rresp,
  input  wire                               step,
  input  wire                               dir,
  input  wire                               analog_cmp1,
  input  wire                               analog_cmp2,
  output logic                              phase_a1_l_out,
  output logic                              phase_a2_l_out,
  output logic                              phase_b1_l_out,
  output logic                              phase_b2_l_out,
  output logic                              phase_a1_h_out,
  output logic                              phase_a2_h_out,
  output logic                              phase_b1_h_out,
  output logic                              phase_b2_h_out,
  output logic                              faultn,
  output logic [stepper_pkg::phase_w-1:0]   phase_ct
);

  logic                            config_enable;
  logic                            config_invert_highside;
  logic                            config_invert_lowside;
  logic [stepper_pkg::off_w-1:0]   config_fastdecay_threshold;
  logic [stepper_pkg::blank_w-1:0] blank_time;
  logic [stepper_pkg::off_w-1:0]   off_time;
  logic [stepper_pkg::blank_w-1:0] min_on_time;
  logic                            s1, s2, s3, s4;
  logic                            offtimer_en0, offtimer_en1;
  logic [stepper_pkg::off_w-1:0]   off_timer0, off_timer1;
  logic [stepper_pkg::blank_w-1:0] blank_timer0, blank_timer1;
  logic [stepper_pkg::blank_w-1:0] minimum_on_timer0, minimum_on_timer1;

  stepper_regs u_regs (
    .clk, .resetn,
    .awaddr, .awvalid, .wdata, .wstrb, .wvalid, .bready,
    .araddr, .arvalid, .rready, .faultn, .phase_ct,
    .awready, .wready, .bvalid, .bresp,
    .arready, .rvalid, .rdata, .rresp,
    .config_enable, .config_invert_highside, .config_invert_lowside,
    .config_fastdecay_threshold, .blank_time, .off_time, .min_on_time
  );

  commutation_decoder u_decoder (
    .phase_ct, .s1, .s2, .s3, .s4
  );

  // Winding A chops on comparator 1
  chopper_timers u_timers_a (
    .clk, .resetn,
    .offtimer_en      (offtimer_en0),
    .off_time, .blank_time, .min_on_time,
    .off_timer        (off_timer0),
    .blank_timer      (blank_timer0),
    .minimum_on_timer (minimum_on_timer0)
  );

  chopper_timers u_timers_b (
    .clk, .resetn,
    .offtimer_en      (offtimer_en1),
    .off_time, .blank_time, .min_on_time,
    .off_timer        (off_timer1),
    .blank_timer      (blank_timer1),
    .minimum_on_timer (minimum_on_timer1)
  );

  microstepper_control u_control (
    .clk, .resetn, .step, .dir,
    .enable_in (config_enable),
    .config_fastdecay_threshold, .config_invert_highside, .config_invert_lowside,
    .analog_cmp1, .analog_cmp2, .s1, .s2, .s3, .s4,
    .blank_timer0, .blank_timer1, .off_timer0, .off_timer1,
    .minimum_on_timer0, .minimum_on_timer1,
    .phase_a1_l_out, .phase_a2_l_out, .phase_b1_l_out, .phase_b2_l_out,
    .phase_a1_h_out, .phase_a2_h_out, .phase_b1_h_out, .phase_b2_h_out,
    .faultn, .offtimer_en0, .offtimer_en1, .phase_ct
  );

endmodule

`default_nettype wire

//--- test/tb_stepper_tests.svh
  int tests_run = 0;
  int tests_failed = 0;
  int errors_at_start = 0;

  task automatic test_begin(input string name);
    test_name = name;
    errors_at_start = error_count;
  endtask

  task automatic test_end();
    // Give checks from the last cycles time to report
    repeat (2) @(posedge clk);
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, error_count - errors_at_start);
    end
  endtask

  task automatic apply_reset();
    resetn   <= 1'b0;
    model_ct <= '0;
    inv_h    <= 1'b0;
    inv_l    <= 1'b0;
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
  endtask

  task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= 4'hf;
    wvalid  <= 1'b1;
    do begin
      @(posedge clk);
    end while (!awready);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    // Invert bits reach the gates right after the completing edge
    if (addr == stepper_pkg::reg_ctrl) begin
      inv_h <= data[1];
      inv_l <= data[2];
    end
    do begin
      @(posedge clk);
    end while (!bvalid);
  endtask

  task automatic axi_read_check(input logic [4:0] addr, input logic [31:0] expected);
    exp_rdata <= expected;
    rd_check  <= 1'b1;
    araddr    <= addr;
    arvalid   <= 1'b1;
    do begin
      @(posedge clk);
    end while (!arready);
    arvalid <= 1'b0;
    do begin
      @(posedge clk);
    end while (!rvalid);
    rd_check <= 1'b0;
  endtask

  task automatic apply_step(input logic up, input int high_len, input int low_len);
    dir <= up;
    repeat (2) @(posedge clk);
    step <= 1'b1;
    repeat (high_len) @(posedge clk);
    step <= 1'b0;
    repeat (low_len) @(posedge clk);
    // One position per pulse, wrapping at 256
    model_ct    <= model_ct + (up ? 8'd1 : 8'hff);
    count_check <= 1'b1;
    @(posedge clk);
    count_check <= 1'b0;
  endtask

  function automatic logic [31:0] field_mask(input logic [4:0] addr);
    case (addr)
      stepper_pkg::reg_ctrl:      return 32'h0000_0007;
      stepper_pkg::reg_fastdecay: return 32'h0000_03ff;
      stepper_pkg::reg_blank:     return 32'h0000_00ff;
      stepper_pkg::reg_off:       return 32'h0000_03ff;
      stepper_pkg::reg_min_on:    return 32'h0000_00ff;
      default:                    return 32'h0000_0000;
    endcase
  endfunction

  initial begin : test_sequence
    int          i;
    int          periods;
    logic [31:0] rand_val;
    logic [4:0]  addr;

    resetn      = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b1;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b1;
    step        = 1'b0;
    dir         = 1'b0;
    analog_cmp1 = 1'b0;
    analog_cmp2 = 1'b0;
    exp_rdata   = '0;
    model_ct    = '0;
    inv_h       = 1'b0;
    inv_l       = 1'b0;
    rd_check    = 1'b0;
    count_check = 1'b0;
    comm_check  = 1'b0;
    brake_check = 1'b0;
    chop_check  = 1'b0;
    fault_check = 1'b0;
    apply_reset();

    test_begin("registers");
    axi_read_check(stepper_pkg::reg_status, 32'h0000_0001);
    for (i = 0; i < 5; i++) begin
      addr     = 5'(i * 4);
      rand_val = $random(seed);
      axi_write(addr, rand_val);
      axi_read_check(addr, rand_val & field_mask(addr));
    end
    // Status and unmapped offsets drop writes
    rand_val = $random(seed);
    axi_write(stepper_pkg::reg_status, rand_val);
    axi_write(5'h18, rand_val);
    axi_read_check(stepper_pkg::reg_status, 32'h0000_0001);
    axi_read_check(5'h18, 32'h0000_0000);
    axi_write(stepper_pkg::reg_ctrl, 32'h0);
    test_end();

    test_begin("step counting");
    for (i = 0; i < 40; i++) begin
      rand_val = $random(seed);
      apply_step(rand_val[0], 4 + int'(rand_val[9:8]), 4 + int'(rand_val[17:16]));
      if (i % 10 == 9) begin
        axi_read_check(stepper_pkg::reg_status, {16'h0, model_ct, 8'h01});
      end
    end
    test_end();

    test_begin("commutation");
    axi_write(stepper_pkg::reg_ctrl, 32'h1);
    for (i = 0; i < 8; i++) begin
      // Second round with both gate groups inverted
      if (i == 4) begin
        axi_write(stepper_pkg::reg_ctrl, 32'h7);
      end
      repeat (2) @(posedge clk);
      comm_check <= 1'b1;
      repeat (4) @(posedge clk);
      comm_check <= 1'b0;
      repeat (64) begin
        apply_step(1'b1, 4, 4);
      end
    end
    test_end();

    test_begin("disable braking");
    brake_check <= 1'b1;
    axi_write(stepper_pkg::reg_ctrl, 32'h0);
    repeat (3) @(posedge clk);
    brake_check <= 1'b0;
    test_end();

    test_begin("chopping and decay");
    axi_write(stepper_pkg::reg_blank, 32'd20);
    axi_write(stepper_pkg::reg_off, 32'd100);
    axi_write(stepper_pkg::reg_min_on, 32'd10);
    axi_write(stepper_pkg::reg_fastdecay, 32'd60);
    axi_write(stepper_pkg::reg_ctrl, 32'h1);
    repeat (2) @(posedge clk);
    chop_check  <= 1'b1;
    analog_cmp1 <= 1'b1;
    periods = 0;
    // Two whole off periods, each closed by drive coming back
    while (periods < 2) begin
      @(posedge clk);
      if (a_drive && slow_run != 0) begin
        periods++;
      end
    end
    analog_cmp1 <= 1'b0;
    repeat (30) @(posedge clk);
    chop_check <= 1'b0;
    test_end();

    test_begin("fault latch");
    // Min on outlasts blanking, so the next off period starts too early
    axi_write(stepper_pkg::reg_min_on, 32'd30);
    analog_cmp1 <= 1'b1;
    do begin
      @(posedge clk);
    end while (faultn);
    fault_check <= 1'b1;
    analog_cmp1 <= 1'b0;
    repeat (120) @(posedge clk);
    axi_read_check(stepper_pkg::reg_status, {16'h0, model_ct, 8'h00});
    fault_check <= 1'b0;
    apply_reset();
    axi_read_check(stepper_pkg::reg_status, 32'h0000_0001);
    test_end();

    $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

//--- test/tb_stepper.sv
`default_nettype none

module tb_stepper;

  timeunit 1ns;
  timeprecision 100ps;

  // Cycle budget of each test
  localparam int axi_cycles     = 6;
  localparam int step_cycles    = 17;
  localparam int reset_len      = 10;
  localparam int regs_len       = 16 * axi_cycles;
  localparam int count_len      = 40 * step_cycles + 4 * axi_cycles;
  localparam int comm_len       = 8 * (6 + 64 * 11) + 2 * axi_cycles;
  localparam int brake_len      = axi_cycles + 4;
  localparam int chop_len       = 5 * axi_cycles + 3 * (100 + 20 + 2) + 40;
  localparam int fault_len      = 3 * axi_cycles + 2 * (100 + 20 + 2) + 140 + reset_len;
  localparam int run_len        = reset_len + regs_len + count_len + comm_len + brake_len +
                                  chop_len + fault_len;
  localparam int timeout_cycles = run_len * 3 / 2;

  logic                            clk;
  logic                            resetn;
  logic [stepper_pkg::addr_w-1:0]  awaddr;
  logic                            awvalid;
  logic                            awready;
  logic [31:0]                     wdata;
  logic [3:0]                      wstrb;
  logic                            wvalid;
  logic                            wready;
  logic                            bvalid;
  logic                            bready;
  logic [1:0]                      bresp;
  logic [stepper_pkg::addr_w-1:0]  araddr;
  logic                            arvalid;
  logic                            arready;
  logic                            rvalid;
  logic                            rready;
  logic [31:0]                     rdata;
  logic [1:0]                      rresp;
  logic                            step;
  logic                            dir;
  logic                            analog_cmp1;
  logic                            analog_cmp2;
  logic                            phase_a1_l_out, phase_a2_l_out, phase_b1_l_out, phase_b2_l_out;
  logic                            phase_a1_h_out, phase_a2_h_out, phase_b1_h_out, phase_b2_h_out;
  logic                            faultn;
  logic [stepper_pkg::phase_w-1:0] phase_ct;

  integer      seed = 32'hdc52_cd48;
  string       test_name = "reset";
  int          error_count = 0;
  logic [31:0] exp_rdata;
  logic [7:0]  model_ct;
  logic        inv_h, inv_l;
  logic        rd_check, count_check, comm_check, brake_check, chop_check, fault_check;
  int          fast_run = 0;
  int          slow_run = 0;
  logic [7:0]  gates, act, exp_gates;
  logic [3:0]  hi_exp, a_bits;
  logic        a_drive, a_fast, a_slow;

  stepper_top u_stepper_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Full step table of the high sides {a1, a2, b1, b2} per quadrant
  function automatic logic [3:0] quadrant_highs(input logic [7:0] ct);
    case (ct[7:6])
      2'd0:    return 4'b1010;
      2'd1:    return 4'b0110;
      2'd2:    return 4'b0101;
      default: return 4'b1001;
    endcase
  endfunction

  assign gates = {phase_a1_h_out, phase_a2_h_out, phase_b1_h_out, phase_b2_h_out,
                  phase_a1_l_out, phase_a2_l_out, phase_b1_l_out, phase_b2_l_out};
  // Gate levels with the output inversion taken out (1 is switch on)
  assign act       = gates ^ {{4{inv_h}}, {4{inv_l}}};
  assign hi_exp    = quadrant_highs(model_ct);
  assign exp_gates = {hi_exp ^ {4{inv_h}}, ~hi_exp ^ {4{inv_l}}};
  assign a_bits    = {act[7:6], act[3:2]};
  assign a_drive   = (a_bits == {hi_exp[3:2], ~hi_exp[3:2]});
  assign a_fast    = (a_bits == {~hi_exp[3:2], hi_exp[3:2]});
  assign a_slow    = (a_bits == 4'b0011);

  // Run lengths of the winding A decay phases while chopping
  always @(posedge clk) begin
    if (!chop_check || a_drive) begin
      fast_run <= 0;
      slow_run <= 0;
    end else begin
      if (a_fast) begin
        fast_run <= fast_run + 1;
      end
      if (a_slow) begin
        slow_run <= slow_run + 1;
      end
    end
  end

  read_value: assert property (@(posedge clk) disable iff (!resetn)
    rd_check && rvalid && rready |-> rdata == exp_rdata)
  else begin
    error_count++;
    $display("error %s: expected 0x%08h, actual 0x%08h", test_name, $sampled(exp_rdata),
             $sampled(rdata));
  end

  write_resp: assert property (@(posedge clk) disable iff (!resetn)
    bvalid |-> bresp == 2'b00)
  else begin
    error_count++;
    $display("error %s: expected bresp 0, actual %0d", test_name, $sampled(bresp));
  end

  read_resp: assert property (@(posedge clk) disable iff (!resetn)
    rvalid |-> rresp == 2'b00)
  else begin
    error_count++;
    $display("error %s: expected rresp 0, actual %0d", test_name, $sampled(rresp));
  end

  ready_pair: assert property (@(posedge clk) disable iff (!resetn)
    awready == wready)
  else begin
    error_count++;
    $display("%s: awready and wready were not raised together", test_name);
  end

  step_count: assert property (@(posedge clk) disable iff (!resetn)
    count_check |-> phase_ct == model_ct)
  else begin
    error_count++;
    $display("error %s: expected phase %0d, actual %0d", test_name, $sampled(model_ct),
             $sampled(phase_ct));
  end

  gate_table: assert property (@(posedge clk) disable iff (!resetn)
    comm_check |-> gates == exp_gates)
  else begin
    error_count++;
    $display("error %s: expected gates 0x%02h, actual 0x%02h", test_name,
             $sampled(exp_gates), $sampled(gates));
  end

  brake_gates: assert property (@(posedge clk) disable iff (!resetn)
    brake_check && awvalid && awready |-> ##2 gates == 8'h0f)
  else begin
    error_count++;
    $display("error %s: expected gates 0x0f, actual 0x%02h", test_name, $sampled(gates));
  end

  chop_pattern: assert property (@(posedge clk) disable iff (!resetn)
    chop_check |-> a_drive || a_fast || a_slow)
  else begin
    error_count++;
    $display("%s: winding A gates show neither drive nor a decay pattern", test_name);
  end

  fast_length: assert property (@(posedge clk) disable iff (!resetn)
    chop_check && a_slow |-> fast_run == 41)
  else begin
    error_count++;
    $display("error %s: expected fast decay of 41 cycles, actual %0d", test_name,
             $sampled(fast_run));
  end

  slow_length: assert property (@(posedge clk) disable iff (!resetn)
    chop_check && a_drive && fast_run != 0 |-> slow_run == 59)
  else begin
    error_count++;
    $display("error %s: expected slow decay of 59 cycles, actual %0d", test_name,
             $sampled(slow_run));
  end

  no_shoot_through: assert property (@(posedge clk) disable iff (!resetn)
    (act[7:4] & act[3:0]) == 4'b0000)
  else begin
    error_count++;
    $display("%s: a half bridge has high and low side on together", test_name);
  end

  fault_hold: assert property (@(posedge clk) disable iff (!resetn)
    fault_check |-> !faultn && act[7:4] == 4'b0000)
  else begin
    error_count++;
    $display("error %s: expected faultn 0 and highs 0000, actual faultn %b and highs %b",
             test_name, $sampled(faultn), $sampled(act[7:4]));
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("watchdog: run timed out after %0d clock cycles", timeout_cycles);
    $display("TESTS FAILED");
    $finish;
  end

  `include "tb_stepper_tests.svh"

endmodule

`default_nettype wire

//--- tb.f
+incdir+test
hw/stepper_pkg.sv
hw/stepper_regs.sv
hw/commutation_decoder.sv
hw/chopper_timers.sv
hw/microstepper_control.sv
hw/stepper_top.sv
test/tb_stepper.sv
